// ==== design/pebPkg.sv ====
/* Shared sizes, beat and memory-port structs and the weight-capture states
   of the processing-element block, used by the RTL and its testbench */
`default_nettype none

package pebPkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int DATA_WIDTH    = 8;
    localparam int CHANNEL_DEPTH = 4;
    localparam int LEN_PSUM      = 4;
    localparam int PSUM_WIDTH    = 20;
    localparam int NUM_PEC       = 3;
    localparam int NUM_BANK      = 2;
    localparam int ADDR_WIDTH    = $clog2(LEN_PSUM);
    localparam int COL_WIDTH     = 2;

    // ======================================================================
    // Types
    // ======================================================================
    // One signed lane, so element selects keep their sign
    typedef logic signed [DATA_WIDTH-1:0] lane_t;

    typedef lane_t [CHANNEL_DEPTH-1:0] act_t;
    typedef lane_t [CHANNEL_DEPTH-1:0] weiVec_t;

    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    typedef struct packed {
        logic                     frtRow;
        logic                     lstRow;
        logic                     lstBlk;
        logic [CHANNEL_DEPTH-1:0] flg;
        act_t                     act;
    } actBeat_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        psum_t                 dat;
    } ramWr_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
    } ramRd_t;

    typedef struct packed {
        logic                  en;
        logic [COL_WIDTH-1:0]  col;
        logic [ADDR_WIDTH-1:0] addr;
    } poolReq_t;

    typedef enum logic [1:0] {
        WEI_IDLE,
        WEI_ACK,
        WEI_HOLD
    } weiState_e;

endpackage

`default_nettype wire

// ==== design/psumRam.sv ====
/* Partial-sum memory, one write port and one read port with registered data */
`timescale 1ns/1ps
`default_nettype none

module psumRam (
    input  wire logic           clk,
    input  wire pebPkg::ramWr_t wr,
    input  wire pebPkg::ramRd_t rd,
    output pebPkg::psum_t       rdDat
);

    // ======================================================================
    // Storage
    // ======================================================================
    pebPkg::psum_t mem [pebPkg::LEN_PSUM];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.dat;
        end
    end

    // Read returns the old word on a same-address collision
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdDat <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/peColumn.sv ====
/* One processing-element column: captures a weight vector, passes activation
   beats on through one register and accumulates masked dot products in memory */
`timescale 1ns/1ps
`default_nettype none

module peColumn (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             weiRdy,
    output logic                  weiGet,
    input  wire pebPkg::weiVec_t  wei,
    input  wire logic             lstRdyAct,
    output logic                  lstGetAct,
    input  wire pebPkg::actBeat_t lstAct,
    output logic                  nxtRdyAct,
    input  wire logic             nxtGetAct,
    output pebPkg::actBeat_t      nxtAct,
    output pebPkg::ramWr_t        ramWr,
    output pebPkg::ramRd_t        ramRd,
    input  wire pebPkg::psum_t    ramDat,
    output logic                  frmDone
);

    // ======================================================================
    // Weight capture
    // ======================================================================
    pebPkg::weiState_e weiState;
    pebPkg::weiVec_t   weiReg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiState <= pebPkg::WEI_IDLE;
        end else begin
            case (weiState)
                pebPkg::WEI_IDLE: if (weiRdy) weiState <= pebPkg::WEI_ACK;
                pebPkg::WEI_ACK:  weiState <= pebPkg::WEI_HOLD;
                pebPkg::WEI_HOLD: if (!weiRdy) weiState <= pebPkg::WEI_IDLE;
                default:          weiState <= pebPkg::WEI_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (weiState == pebPkg::WEI_IDLE && weiRdy) begin
            weiReg <= wei;
        end
    end

    // Single-cycle acknowledge
    assign weiGet = (weiState == pebPkg::WEI_ACK);

    // ======================================================================
    // Activation pass-through
    // ======================================================================
    logic                  outValid;
    pebPkg::actBeat_t      outBeat;
    logic                  accept;
    logic [pebPkg::ADDR_WIDTH-1:0] rdAddr;

    // Take a beat when the output slot is free or drains this cycle
    assign lstGetAct = lstRdyAct && (!outValid || nxtGetAct);
    assign accept    = lstGetAct;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (nxtGetAct) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outBeat <= lstAct;
        end
    end

    assign nxtRdyAct = outValid;
    assign nxtAct    = outBeat;

    // Row position of the next accepted beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdAddr <= '0;
        end else if (accept) begin
            if (rdAddr == pebPkg::ADDR_WIDTH'(pebPkg::LEN_PSUM - 1)) begin
                rdAddr <= '0;
            end else begin
                rdAddr <= rdAddr + 1'b1;
            end
        end
    end

    // ======================================================================
    // Multiply-accumulate
    // ======================================================================
    pebPkg::psum_t dotSum;
    logic          pipeEn;
    logic          pipeFrt;
    logic          pipeLast;
    logic [pebPkg::ADDR_WIDTH-1:0] pipeAddr;
    pebPkg::psum_t pipeProd;
    logic          wrEn;
    logic          wrLast;
    logic [pebPkg::ADDR_WIDTH-1:0] wrAddr;
    pebPkg::psum_t wrDat;

    // Lanes with a clear flag contribute nothing
    always_comb begin
        dotSum = '0;
        for (int i = 0; i < pebPkg::CHANNEL_DEPTH; i++) begin
            if (lstAct.flg[i]) begin
                dotSum = dotSum + pebPkg::psum_t'(lstAct.act[i])
                                * pebPkg::psum_t'(weiReg[i]);
            end
        end
    end

    assign ramRd = '{en: accept, addr: rdAddr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipeEn  <= 1'b0;
            wrEn    <= 1'b0;
            frmDone <= 1'b0;
        end else begin
            pipeEn  <= accept;
            wrEn    <= pipeEn;
            frmDone <= wrEn && wrLast;
        end
    end

    // Stage 1 holds the product while the old sum is read
    always_ff @(posedge clk) begin
        if (accept) begin
            pipeProd <= dotSum;
            pipeAddr <= rdAddr;
            pipeFrt  <= lstAct.frtRow;
            pipeLast <= lstAct.lstRow && lstAct.lstBlk
                        && (rdAddr == pebPkg::ADDR_WIDTH'(pebPkg::LEN_PSUM - 1));
        end
    end

    // Stage 2 registers the new sum for the write port
    always_ff @(posedge clk) begin
        if (pipeEn) begin
            wrAddr <= pipeAddr;
            wrDat  <= (pipeFrt ? pebPkg::psum_t'(0) : ramDat) + pipeProd;
            wrLast <= pipeLast;
        end
    end

    assign ramWr = '{en: wrEn, addr: wrAddr, dat: wrDat};

endmodule

`default_nettype wire

// ==== design/peBlock.sv ====
/* Processing-element block: three chained columns, each with a ping-pong pair
   of partial-sum memories, and a read port for the pooling stage */
`timescale 1ns/1ps
`default_nettype none

module peBlock (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [pebPkg::NUM_PEC-1:0]  weiRdy,
    output logic      [pebPkg::NUM_PEC-1:0]  weiGet,
    input  wire pebPkg::weiVec_t             wei,
    input  wire logic                        lstRdyAct,
    output logic                             lstGetAct,
    input  wire pebPkg::actBeat_t            lstAct,
    output logic                             nxtRdyAct,
    input  wire logic                        nxtGetAct,
    output pebPkg::actBeat_t                 nxtAct,
    input  wire pebPkg::poolReq_t            poolReq,
    output pebPkg::psum_t                    poolDat,
    output logic                             frmDone
);

    // ======================================================================
    // Signals
    // ======================================================================
    // Beat chain, index c feeds column c and index NUM_PEC leaves the block
    logic             rdy  [pebPkg::NUM_PEC+1];
    logic             get  [pebPkg::NUM_PEC+1];
    pebPkg::actBeat_t beat [pebPkg::NUM_PEC+1];

    pebPkg::ramWr_t   colWr   [pebPkg::NUM_PEC];
    pebPkg::ramRd_t   colRd   [pebPkg::NUM_PEC];
    pebPkg::psum_t    colDat  [pebPkg::NUM_PEC];
    logic             colDone [pebPkg::NUM_PEC];

    pebPkg::ramWr_t   memWr  [pebPkg::NUM_PEC][pebPkg::NUM_BANK];
    pebPkg::ramRd_t   memRd  [pebPkg::NUM_PEC][pebPkg::NUM_BANK];
    pebPkg::psum_t    memDat [pebPkg::NUM_PEC][pebPkg::NUM_BANK];

    logic                         bankSel;
    logic [pebPkg::COL_WIDTH-1:0] poolColQ;
    logic                         poolBankQ;

    // ======================================================================
    // Chain ends
    // ======================================================================
    assign rdy[0]                = lstRdyAct;
    assign beat[0]               = lstAct;
    assign lstGetAct             = get[0];
    assign nxtRdyAct             = rdy[pebPkg::NUM_PEC];
    assign nxtAct                = beat[pebPkg::NUM_PEC];
    assign get[pebPkg::NUM_PEC]  = nxtGetAct;

    // ======================================================================
    // Ping-pong bank flag
    // ======================================================================
    // The last column closes the frame for the whole block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bankSel <= 1'b0;
        end else if (colDone[pebPkg::NUM_PEC-1]) begin
            bankSel <= ~bankSel;
        end
    end

    assign frmDone = colDone[pebPkg::NUM_PEC-1];

    // ======================================================================
    // Memory routing
    // ======================================================================
    always_comb begin
        for (int c = 0; c < pebPkg::NUM_PEC; c++) begin
            for (int b = 0; b < pebPkg::NUM_BANK; b++) begin
                if (bankSel == 1'(b)) begin
                    // Active bank belongs to the column
                    memWr[c][b] = colWr[c];
                    memRd[c][b] = colRd[c];
                end else begin
                    // Idle bank serves the pooling stage
                    memWr[c][b]      = '0;
                    memRd[c][b].en   = poolReq.en
                                       && (poolReq.col == pebPkg::COL_WIDTH'(c));
                    memRd[c][b].addr = poolReq.addr;
                end
            end
            colDat[c] = bankSel ? memDat[c][1] : memDat[c][0];
        end
    end

    // Remember where the pool read went
    always_ff @(posedge clk) begin
        if (poolReq.en) begin
            poolColQ  <= poolReq.col;
            poolBankQ <= ~bankSel;
        end
    end

    always_comb begin
        if (poolColQ < pebPkg::COL_WIDTH'(pebPkg::NUM_PEC)) begin
            poolDat = memDat[poolColQ][poolBankQ];
        end else begin
            poolDat = '0;
        end
    end

    // ======================================================================
    // Columns and memories
    // ======================================================================
    for (genvar c = 0; c < pebPkg::NUM_PEC; c++) begin : gCol
        peColumn col_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .weiRdy    (weiRdy[c]),
            .weiGet    (weiGet[c]),
            .wei       (wei),
            .lstRdyAct (rdy[c]),
            .lstGetAct (get[c]),
            .lstAct    (beat[c]),
            .nxtRdyAct (rdy[c+1]),
            .nxtGetAct (get[c+1]),
            .nxtAct    (beat[c+1]),
            .ramWr     (colWr[c]),
            .ramRd     (colRd[c]),
            .ramDat    (colDat[c]),
            .frmDone   (colDone[c])
        );

        for (genvar b = 0; b < pebPkg::NUM_BANK; b++) begin : gBank
            psumRam ram_i (
                .clk   (clk),
                .wr    (memWr[c][b]),
                .rd    (memRd[c][b]),
                .rdDat (memDat[c][b])
            );
        end
    end

endmodule

`default_nettype wire

// ==== verif/peBlockChecker.sv ====
/* Watches the processing-element block ports, models the expected partial sums
   and counts every mismatch for the testbench */
`timescale 1ns/1ps
`default_nettype none

module peBlockChecker (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [pebPkg::NUM_PEC-1:0] weiRdy,
    input  wire logic [pebPkg::NUM_PEC-1:0] weiGet,
    input  wire pebPkg::weiVec_t            wei,
    input  wire logic                       lstRdyAct,
    input  wire logic                       lstGetAct,
    input  wire pebPkg::actBeat_t           lstAct,
    input  wire logic                       nxtRdyAct,
    input  wire logic                       nxtGetAct,
    input  wire pebPkg::actBeat_t           nxtAct,
    input  wire pebPkg::poolReq_t           poolReq,
    input  wire pebPkg::psum_t              poolDat,
    input  wire logic                       frmDone,
    input  wire logic                       endRun,
    output int                              errCnt,
    output logic                            endDone
);

    pebPkg::weiVec_t            weiSeen [pebPkg::NUM_PEC];
    int                         reqCnt  [pebPkg::NUM_PEC] = '{default: 0};
    int                         getCnt  [pebPkg::NUM_PEC] = '{default: 0};
    logic [pebPkg::NUM_PEC-1:0] weiRdyQ;
    logic [pebPkg::NUM_PEC-1:0] weiGetQ;
    pebPkg::actBeat_t           allBeats [$];
    pebPkg::actBeat_t           pendQ [$];
    pebPkg::actBeat_t           expBeat;
    int                         frmEnd [$];
    int                         inCnt = 0;
    int                         outCnt = 0;
    int                         doneCnt = 0;
    logic                       poolPend = 1'b0;
    int                         poolCol;
    int                         poolAddr;
    pebPkg::psum_t              poolExp;

    initial begin
        errCnt  = 0;
        endDone = 1'b0;
    end

    task automatic logError(input string msg);
        errCnt++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    // Address k collects every beat whose global index is k modulo the row
    // length, and a first-row beat restarts the sum
    function automatic pebPkg::psum_t refPsum(input int col, input int addr, input int frame);
        int               lo;
        int               acc;
        int               dot;
        pebPkg::actBeat_t b;
        lo  = (frame == 0) ? 0 : frmEnd[frame-1] + 1;
        acc = 0;
        for (int i = lo; i <= frmEnd[frame]; i++) begin
            b = allBeats[i];
            if (i % pebPkg::LEN_PSUM == addr) begin
                dot = 0;
                for (int l = 0; l < pebPkg::CHANNEL_DEPTH; l++) begin
                    if (b.flg[l]) dot += int'(b.act[l]) * int'(weiSeen[col][l]);
                end
                acc = b.frtRow ? dot : acc + dot;
            end
        end
        return pebPkg::psum_t'(acc);
    endfunction

    // ======================================================================
    // Port monitor
    // ======================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            if (weiGet != '0 || nxtRdyAct || lstGetAct || frmDone) begin
                logError("outputs not idle during reset");
            end
            weiRdyQ = '0;
            weiGetQ = '0;
        end else begin
            // One acknowledge per request, never two cycles long
            for (int c = 0; c < pebPkg::NUM_PEC; c++) begin
                if (weiRdy[c] && !weiRdyQ[c]) reqCnt[c]++;
                if (weiGet[c]) begin
                    getCnt[c]++;
                    weiSeen[c] = wei;
                    if (weiGetQ[c]) logError($sformatf("weiGet[%0d] high twice in a row", c));
                end
            end
            weiRdyQ = weiRdy;
            weiGetQ = weiGet;

            if (lstRdyAct && lstGetAct) begin
                pendQ.push_back(lstAct);
                allBeats.push_back(lstAct);
                if (lstAct.lstRow && lstAct.lstBlk
                    && inCnt % pebPkg::LEN_PSUM == pebPkg::LEN_PSUM - 1) begin
                    frmEnd.push_back(inCnt);
                end
                inCnt++;
            end

            if (nxtRdyAct && nxtGetAct) begin
                outCnt++;
                if (pendQ.size() == 0) begin
                    logError("beat left the block with none pending");
                end else begin
                    expBeat = pendQ.pop_front();
                    if (nxtAct !== expBeat) begin
                        logError($sformatf("nxtAct %h, expected %h", nxtAct, expBeat));
                    end
                end
            end

            if (frmDone) doneCnt++;

            // Data of the previous request is on poolDat now
            if (poolPend && poolDat !== poolExp) begin
                logError($sformatf("pool col %0d addr %0d read %0d, expected %0d",
                                   poolCol, poolAddr, poolDat, poolExp));
            end
            poolPend = poolReq.en;
            if (poolReq.en) begin
                poolCol  = int'(poolReq.col);
                poolAddr = int'(poolReq.addr);
                if (doneCnt == 0 || doneCnt > frmEnd.size()) begin
                    logError("pool read with no finished frame");
                    poolPend = 1'b0;
                end else begin
                    poolExp = refPsum(poolCol, poolAddr, doneCnt - 1);
                end
            end

            if (endRun && !endDone) begin
                if (inCnt != outCnt) begin
                    logError($sformatf("%0d beats in, %0d beats out", inCnt, outCnt));
                end
                if (doneCnt != frmEnd.size()) begin
                    logError($sformatf("%0d frmDone pulses for %0d frames", doneCnt,
                                       frmEnd.size()));
                end
                for (int c = 0; c < pebPkg::NUM_PEC; c++) begin
                    if (getCnt[c] != reqCnt[c]) begin
                        logError($sformatf("column %0d: %0d weiGet pulses for %0d requests",
                                           c, getCnt[c], reqCnt[c]));
                    end
                end
                endDone = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/peBlockTb.sv ====
/* Testbench for the processing-element block: loads weights, streams frames
   under random back-pressure and reads both ping-pong banks back */
`timescale 1ns/1ps
`default_nettype none

module peBlockTb;

    localparam int NUM_FRAME       = 3;
    localparam int NUM_ROW         = 3;
    localparam int WATCHDOG_CYCLES = NUM_FRAME * NUM_ROW * pebPkg::LEN_PSUM * 20 + 200;

    logic                       clk;
    logic                       rst_n;
    logic [pebPkg::NUM_PEC-1:0] weiRdy;
    logic [pebPkg::NUM_PEC-1:0] weiGet;
    pebPkg::weiVec_t            wei;
    logic                       lstRdyAct;
    logic                       lstGetAct;
    pebPkg::actBeat_t           lstAct;
    logic                       nxtRdyAct;
    logic                       nxtGetAct;
    pebPkg::actBeat_t           nxtAct;
    pebPkg::poolReq_t           poolReq;
    pebPkg::psum_t              poolDat;
    logic                       frmDone;
    logic                       endRun;
    logic                       endDone;
    int                         errCnt;
    int                         seed;

    peBlock dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .weiRdy    (weiRdy),
        .weiGet    (weiGet),
        .wei       (wei),
        .lstRdyAct (lstRdyAct),
        .lstGetAct (lstGetAct),
        .lstAct    (lstAct),
        .nxtRdyAct (nxtRdyAct),
        .nxtGetAct (nxtGetAct),
        .nxtAct    (nxtAct),
        .poolReq   (poolReq),
        .poolDat   (poolDat),
        .frmDone   (frmDone)
    );

    peBlockChecker check_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .weiRdy    (weiRdy),
        .weiGet    (weiGet),
        .wei       (wei),
        .lstRdyAct (lstRdyAct),
        .lstGetAct (lstGetAct),
        .lstAct    (lstAct),
        .nxtRdyAct (nxtRdyAct),
        .nxtGetAct (nxtGetAct),
        .nxtAct    (nxtAct),
        .poolReq   (poolReq),
        .poolDat   (poolDat),
        .frmDone   (frmDone),
        .endRun    (endRun),
        .errCnt    (errCnt),
        .endDone   (endDone)
    );

    always #5 clk = ~clk;

    // Output side takes a beat in about 70% of the cycles
    always @(posedge clk) begin
        #1;
        nxtGetAct = ($unsigned($random(seed)) % 10) >= 3;
    end

    // ======================================================================
    // Stimulus tasks, each entered and left 1 ns after a rising edge
    // ======================================================================
    task automatic loadWeights();
        for (int c = 0; c < pebPkg::NUM_PEC; c++) begin
            wei       = $random(seed);
            weiRdy[c] = 1'b1;
            @(posedge clk);
            while (!weiGet[c]) @(posedge clk);
            // Request stays up a while, no second pulse may follow
            repeat (3) @(posedge clk);
            #1;
            weiRdy[c] = 1'b0;
        end
    endtask

    task automatic sendRows(input int firstRow, input int lastRow);
        pebPkg::actBeat_t beat;
        for (int r = firstRow; r <= lastRow; r++) begin
            for (int k = 0; k < pebPkg::LEN_PSUM; k++) begin
                beat.frtRow = (r == 0);
                beat.lstRow = (r == NUM_ROW - 1);
                beat.lstBlk = (r == NUM_ROW - 1);
                beat.flg    = pebPkg::CHANNEL_DEPTH'($random(seed));
                beat.act    = $random(seed);
                lstAct      = beat;
                lstRdyAct   = 1'b1;
                @(posedge clk);
                while (!lstGetAct) @(posedge clk);
                #1;
            end
        end
        lstRdyAct = 1'b0;
    endtask

    task automatic readPool();
        for (int c = 0; c < pebPkg::NUM_PEC; c++) begin
            for (int a = 0; a < pebPkg::LEN_PSUM; a++) begin
                poolReq.en   = 1'b1;
                poolReq.col  = pebPkg::COL_WIDTH'(c);
                poolReq.addr = pebPkg::ADDR_WIDTH'(a);
                @(posedge clk);
                #1;
            end
        end
        poolReq.en = 1'b0;
    endtask

    task automatic waitFrame();
        @(posedge clk);
        while (!frmDone) @(posedge clk);
        #1;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        seed      = 32'h94bd9346;
        clk       = 1'b0;
        rst_n     = 1'b1;
        weiRdy    = '0;
        wei       = '0;
        lstRdyAct = 1'b0;
        lstAct    = '0;
        nxtGetAct = 1'b0;
        poolReq   = '0;
        endRun    = 1'b0;
        // Give the asynchronous clear a real falling edge
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        loadWeights();
        for (int f = 0; f < NUM_FRAME; f++) begin
            if (f == 0) begin
                sendRows(0, NUM_ROW - 1);
            end else begin
                // Previous frame is still readable from the idle bank
                sendRows(0, 0);
                readPool();
                sendRows(1, NUM_ROW - 1);
            end
            waitFrame();
            readPool();
        end

        // Drain the output register before the final counts
        @(posedge clk);
        while (nxtRdyAct) @(posedge clk);
        #1;
        endRun = 1'b1;
        @(posedge clk);
        while (!endDone) @(posedge clk);

        $display("Errors: %0d", errCnt);
        if (errCnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run not finished after %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errCnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/pebPkg.sv
design/psumRam.sv
design/peColumn.sv
design/peBlock.sv
verif/peBlockChecker.sv
verif/peBlockTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log

verilator --binary --timing -f files.f --top-module peBlockTb -o peBlockSim \
    && ./obj_dir/peBlockSim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
